//--- hdl/csr_pkg.sv
////////////////////////////////////////
// CSR address and operation encodings, request and control
// structs, register masks and reset values
////////////////////////////////////////

package csr_pkg;

  // Width of every CSR
  localparam int XLEN = 32;

  ////////////////////////////////////////
  // Field positions
  ////////////////////////////////////////

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  // MPP is hardwired to machine mode
  localparam logic [1:0] MSTATUS_MPP_M = 2'b11;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MHARTID  = 12'hF14
  } csr_num_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // CSR access presented by the write-back stage
  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    csr_num_e        addr;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  // Command from the controller FSM
  typedef struct packed {
    logic            kill_wb;
    logic            halt_wb;
    logic            csr_save_cause;
    logic            csr_restore_mret;
    logic            cause_irq;
    logic [4:0]      cause_code;
    logic [XLEN-1:0] pipe_pc;
  } ctrl_t;

  // One-hot select of a writable register
  typedef struct packed {
    logic mstatus;
    logic mie;
    logic mtvec;
    logic mscratch;
    logic mepc;
    logic mcause;
  } csr_sel_t;

  ////////////////////////////////////////
  // Masks and reset values
  ////////////////////////////////////////

  localparam logic [XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088;
  localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
  localparam logic [XLEN-1:0] MCAUSE_WMASK  = 32'h8000_001F;
  localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFE;
  localparam logic [XLEN-1:0] MTVEC_RESET   = 32'h0000_0100;
  localparam logic [XLEN-1:0] MHARTID_VALUE = 32'h0000_0000;

endpackage

//--- hdl/csr_decode.sv
////////////////////////////////////////
// CSR address decoder and read data mux
////////////////////////////////////////

`timescale 1ns/1ps

module csr_decode (
  input  csr_pkg::csr_num_e           addr_i,
  input  logic [csr_pkg::XLEN-1:0]    mstatus_i,
  input  logic [csr_pkg::XLEN-1:0]    mie_i,
  input  logic [csr_pkg::XLEN-1:0]    mtvec_i,
  input  logic [csr_pkg::XLEN-1:0]    mscratch_i,
  input  logic [csr_pkg::XLEN-1:0]    mepc_i,
  input  logic [csr_pkg::XLEN-1:0]    mcause_i,
  output csr_pkg::csr_sel_t           sel_o,
  output logic                        known_o,
  output logic                        read_only_o,
  output logic [csr_pkg::XLEN-1:0]    rdata_o
);

  import csr_pkg::*;

  // Unknown addresses select nothing and read as zero
  always_comb begin
    sel_o       = '0;
    known_o     = 1'b1;
    read_only_o = 1'b0;
    rdata_o     = '0;
    case (addr_i)
      CSR_MSTATUS: begin
        sel_o.mstatus = 1'b1;
        rdata_o       = mstatus_i;
      end
      CSR_MIE: begin
        sel_o.mie = 1'b1;
        rdata_o   = mie_i;
      end
      CSR_MTVEC: begin
        sel_o.mtvec = 1'b1;
        rdata_o     = mtvec_i;
      end
      CSR_MSCRATCH: begin
        sel_o.mscratch = 1'b1;
        rdata_o        = mscratch_i;
      end
      CSR_MEPC: begin
        sel_o.mepc = 1'b1;
        rdata_o    = mepc_i;
      end
      CSR_MCAUSE: begin
        sel_o.mcause = 1'b1;
        rdata_o      = mcause_i;
      end
      CSR_MHARTID: begin
        // Constant, no storage behind it
        read_only_o = 1'b1;
        rdata_o     = MHARTID_VALUE;
      end
      default: begin
        known_o = 1'b0;
      end
    endcase
  end

endmodule

//--- hdl/csr_write_unit.sv
////////////////////////////////////////
// CSR operation, write intent and illegal access check
////////////////////////////////////////

`timescale 1ns/1ps

module csr_write_unit (
  input  csr_pkg::csr_req_t           req_i,
  input  logic                        kill_wb_i,
  input  logic                        halt_wb_i,
  input  logic                        known_i,
  input  logic                        read_only_i,
  input  logic [csr_pkg::XLEN-1:0]    old_i,
  output logic                        we_o,
  output logic                        illegal_o,
  output logic [csr_pkg::XLEN-1:0]    wdata_o
);

  import csr_pkg::*;

  logic exec;
  logic set_clear;
  logic intent;

  // A killed or halted write-back stage executes nothing
  assign exec = req_i.valid && !kill_wb_i && !halt_wb_i;

  assign set_clear = (req_i.op == CSR_OP_SET) || (req_i.op == CSR_OP_CLEAR);

  // Set or clear with an all-zero operand is treated as a pure read
  assign intent = (req_i.op == CSR_OP_WRITE) || (set_clear && (|req_i.wdata));

  assign illegal_o = exec && (!known_i || (read_only_i && intent));

  assign we_o = exec && intent && known_i && !read_only_i;

  // New value before the register's writable mask
  always_comb begin
    case (req_i.op)
      CSR_OP_WRITE: wdata_o = req_i.wdata;
      CSR_OP_SET:   wdata_o = old_i | req_i.wdata;
      CSR_OP_CLEAR: wdata_o = old_i & ~req_i.wdata;
      default:      wdata_o = old_i;
    endcase
  end

endmodule

//--- hdl/csr_regs.sv
////////////////////////////////////////
// Machine-mode CSR storage with masked writes,
// trap save and mret restore
////////////////////////////////////////

`timescale 1ns/1ps

module csr_regs (
  input  logic                        clk,
  input  logic                        rst_i,
  input  csr_pkg::csr_sel_t           sel_i,
  input  logic                        we_i,
  input  logic [csr_pkg::XLEN-1:0]    wdata_i,
  input  csr_pkg::ctrl_t              ctrl_i,
  output logic [csr_pkg::XLEN-1:0]    mstatus_o,
  output logic [csr_pkg::XLEN-1:0]    mie_o,
  output logic [csr_pkg::XLEN-1:0]    mtvec_o,
  output logic [csr_pkg::XLEN-1:0]    mscratch_o,
  output logic [csr_pkg::XLEN-1:0]    mepc_o,
  output logic [csr_pkg::XLEN-1:0]    mcause_o
);

  import csr_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  logic            csr_we;
  logic [XLEN-1:0] mtvec_wr;
  logic [XLEN-1:0] cause_wr;

  ////////////////////////////////////////
  // Write preparation
  ////////////////////////////////////////

  // Trap save and mret both drop a CSR write in the same cycle
  assign csr_we = we_i && !ctrl_i.csr_save_cause && !ctrl_i.csr_restore_mret;

  // Modes 2 and 3 are reserved, so the old mode is kept
  assign mtvec_wr = wdata_i[1] ? {wdata_i[XLEN-1:2], mtvec_q[1:0]} : wdata_i;

  assign cause_wr = {ctrl_i.cause_irq, {(XLEN-6){1'b0}}, ctrl_i.cause_code};

  ////////////////////////////////////////
  // mstatus
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mstatus_q <= '0;
    end else if (ctrl_i.csr_save_cause) begin
      mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
      mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
    end else if (ctrl_i.csr_restore_mret) begin
      mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
      mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
    end else if (csr_we && sel_i.mstatus) begin
      mstatus_q <= wdata_i & MSTATUS_WMASK;
    end
  end

  ////////////////////////////////////////
  // mepc and mcause
  ////////////////////////////////////////

  // Both are loaded together on a trap save
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (ctrl_i.csr_save_cause) begin
      mepc_q   <= ctrl_i.pipe_pc & MEPC_WMASK;
      mcause_q <= cause_wr & MCAUSE_WMASK;
    end else begin
      if (csr_we && sel_i.mepc) begin
        mepc_q <= wdata_i & MEPC_WMASK;
      end
      if (csr_we && sel_i.mcause) begin
        mcause_q <= wdata_i & MCAUSE_WMASK;
      end
    end
  end

  ////////////////////////////////////////
  // mie, mtvec and mscratch
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RESET;
      mscratch_q <= '0;
    end else if (csr_we) begin
      if (sel_i.mie) begin
        mie_q <= wdata_i & MIE_WMASK;
      end
      if (sel_i.mtvec) begin
        mtvec_q <= mtvec_wr;
      end
      if (sel_i.mscratch) begin
        mscratch_q <= wdata_i;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // MPP is not stored and always reads as machine mode
  assign mstatus_o  = mstatus_q | (XLEN'(MSTATUS_MPP_M) << MSTATUS_MPP_LSB);
  assign mie_o      = mie_q;
  assign mtvec_o    = mtvec_q;
  assign mscratch_o = mscratch_q;
  assign mepc_o     = mepc_q;
  assign mcause_o   = mcause_q;

endmodule

//--- hdl/csr_top.sv
////////////////////////////////////////
// Machine-mode CSR file top level
////////////////////////////////////////

`timescale 1ns/1ps

module csr_top (
  input  logic                        clk,
  input  logic                        rst_i,
  input  csr_pkg::csr_req_t           req_i,
  input  csr_pkg::ctrl_t              ctrl_i,
  output logic [csr_pkg::XLEN-1:0]    rdata_o,
  output logic                        illegal_o,
  output logic [csr_pkg::XLEN-1:0]    mtvec_o,
  output logic [csr_pkg::XLEN-1:0]    mepc_o,
  output logic                        irq_en_o
);

  import csr_pkg::*;

  csr_sel_t        sel;
  logic            known;
  logic            read_only;
  logic            we;
  logic [XLEN-1:0] new_val;
  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mie;
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mcause;

  csr_decode u_decode (
    .addr_i      (req_i.addr),
    .mstatus_i   (mstatus),
    .mie_i       (mie),
    .mtvec_i     (mtvec_o),
    .mscratch_i  (mscratch),
    .mepc_i      (mepc_o),
    .mcause_i    (mcause),
    .sel_o       (sel),
    .known_o     (known),
    .read_only_o (read_only),
    .rdata_o     (rdata_o)
  );

  csr_write_unit u_write_unit (
    .req_i       (req_i),
    .kill_wb_i   (ctrl_i.kill_wb),
    .halt_wb_i   (ctrl_i.halt_wb),
    .known_i     (known),
    .read_only_i (read_only),
    .old_i       (rdata_o),
    .we_o        (we),
    .illegal_o   (illegal_o),
    .wdata_o     (new_val)
  );

  csr_regs u_regs (
    .clk        (clk),
    .rst_i      (rst_i),
    .sel_i      (sel),
    .we_i       (we),
    .wdata_i    (new_val),
    .ctrl_i     (ctrl_i),
    .mstatus_o  (mstatus),
    .mie_o      (mie),
    .mtvec_o    (mtvec_o),
    .mscratch_o (mscratch),
    .mepc_o     (mepc_o),
    .mcause_o   (mcause)
  );

  // Global interrupt enable
  assign irq_en_o = mstatus[MSTATUS_MIE_BIT];

endmodule

//--- tb/csr_model.svh
////////////////////////////////////////
// Reference model of the CSR file state and its update rules
////////////////////////////////////////

`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic [XLEN-1:0] m_mstatus;
logic [XLEN-1:0] m_mie;
logic [XLEN-1:0] m_mtvec;
logic [XLEN-1:0] m_mscratch;
logic [XLEN-1:0] m_mepc;
logic [XLEN-1:0] m_mcause;

task automatic model_reset();
  m_mstatus  = '0;
  m_mie      = '0;
  m_mtvec    = MTVEC_RESET;
  m_mscratch = '0;
  m_mepc     = '0;
  m_mcause   = '0;
endtask

// MPP always reads as machine mode, unknown addresses read as zero
function automatic logic [XLEN-1:0] model_read(csr_num_e addr);
  case (addr)
    CSR_MSTATUS:  return m_mstatus | {19'd0, MSTATUS_MPP_M, 11'd0};
    CSR_MIE:      return m_mie;
    CSR_MTVEC:    return m_mtvec;
    CSR_MSCRATCH: return m_mscratch;
    CSR_MEPC:     return m_mepc;
    CSR_MCAUSE:   return m_mcause;
    CSR_MHARTID:  return MHARTID_VALUE;
    default:      return '0;
  endcase
endfunction

// A set or clear with a zero operand only reads
function automatic logic model_intent(csr_req_t req);
  return (req.op == CSR_OP_WRITE) || (req.op != CSR_OP_READ && req.wdata != '0);
endfunction

function automatic logic model_exec(csr_req_t req, ctrl_t ctrl);
  return req.valid && !ctrl.kill_wb && !ctrl.halt_wb;
endfunction

function automatic logic model_illegal(csr_req_t req, ctrl_t ctrl);
  logic known;
  known = req.addr inside {CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                           CSR_MEPC, CSR_MCAUSE, CSR_MHARTID};
  return model_exec(req, ctrl) &&
         (!known || (req.addr == CSR_MHARTID && model_intent(req)));
endfunction

// Trap save wins over mret, and both drop a CSR write
task automatic model_step(csr_req_t req, ctrl_t ctrl);
  logic [XLEN-1:0] old;
  logic [XLEN-1:0] res;
  logic            we;
  old = model_read(req.addr);
  we  = model_exec(req, ctrl) && model_intent(req) && !model_illegal(req, ctrl);
  case (req.op)
    CSR_OP_WRITE: res = req.wdata;
    CSR_OP_SET:   res = old | req.wdata;
    CSR_OP_CLEAR: res = old & ~req.wdata;
    default:      res = old;
  endcase
  if (ctrl.csr_save_cause) begin
    m_mepc   = ctrl.pipe_pc & ~32'h1;
    m_mcause = {ctrl.cause_irq, 26'd0, ctrl.cause_code};
    m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
    m_mstatus[MSTATUS_MIE_BIT]  = 1'b0;
  end else if (ctrl.csr_restore_mret) begin
    m_mstatus[MSTATUS_MIE_BIT]  = m_mstatus[MSTATUS_MPIE_BIT];
    m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
  end else if (we) begin
    case (req.addr)
      CSR_MSTATUS:  m_mstatus = res & MSTATUS_WMASK;
      CSR_MIE:      m_mie = res & MIE_WMASK;
      // Reserved modes 2 and 3 keep the old mode
      CSR_MTVEC:    m_mtvec = (res[1:0] >= 2'd2) ? {res[31:2], m_mtvec[1:0]} : res;
      CSR_MSCRATCH: m_mscratch = res;
      CSR_MEPC:     m_mepc = res & ~32'h1;
      CSR_MCAUSE:   m_mcause = res & MCAUSE_WMASK;
      default:      ;
    endcase
  end
endtask

`endif

//--- tb/csr_tb.sv
////////////////////////////////////////
// Testbench for the machine-mode CSR file
////////////////////////////////////////

`timescale 1ns/1ps

module csr_tb;

  import csr_pkg::*;

  // Directed tests stay below DIRECTED_OPS cycles in total
  localparam int RAND_OPS     = 200;
  localparam int DIRECTED_OPS = 120;
  localparam int TIMEOUT_NS   = (2 + RAND_OPS + DIRECTED_OPS) * 10 + 500;

  logic            clk;
  logic            rst_i;
  csr_req_t        req_i;
  ctrl_t           ctrl_i;
  logic [XLEN-1:0] rdata_o;
  logic            illegal_o;
  logic [XLEN-1:0] mtvec_o;
  logic [XLEN-1:0] mepc_o;
  logic            irq_en_o;

  integer seed = 3;
  int     errors;
  int     test_errors;
  int     checks;
  string  test_name;

  csr_num_e addr_list [7] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                              CSR_MEPC, CSR_MCAUSE, CSR_MHARTID};

  csr_top DUT (.*);

  `include "csr_model.svh"

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Compare and drive tasks
  ////////////////////////////////////////

  task automatic check_data(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  // Registered outputs are checked first, then the combinational
  // response to the new request, before the model advances
  task automatic present(csr_req_t req, ctrl_t ctrl);
    @(negedge clk);
    check_data("mtvec_o", m_mtvec, mtvec_o);
    check_data("mepc_o", m_mepc, mepc_o);
    check_flag("irq_en_o", m_mstatus[MSTATUS_MIE_BIT], irq_en_o);
    req_i  = req;
    ctrl_i = ctrl;
    #1;
    check_data("rdata_o", model_read(req.addr), rdata_o);
    check_flag("illegal_o", model_illegal(req, ctrl), illegal_o);
    model_step(req, ctrl);
  endtask

  task automatic access(csr_op_e op, csr_num_e addr, logic [XLEN-1:0] wdata, ctrl_t ctrl);
    csr_req_t req;
    req.valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    present(req, ctrl);
  endtask

  task automatic read_all();
    foreach (addr_list[i]) begin
      access(CSR_OP_READ, addr_list[i], '0, '0);
    end
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, test_errors);
    test_errors = 0;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    ctrl_t           ct;
    csr_req_t        rq;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] wd;
    logic [2:0]      idx;
    clk         = 1'b0;
    rst_i       = 1'b1;
    req_i       = '0;
    ctrl_i      = '0;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    model_reset();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    test_name = "reset_values";
    read_all();
    end_test();

    test_name = "random_ops";
    for (int i = 0; i < RAND_OPS; i++) begin
      r   = $random(seed);
      wd  = $random(seed);
      idx = 3'(r[6:2] % 6);
      // About one operand in eight is zero
      if (r[9:7] == 3'd0) begin
        wd = '0;
      end
      access(csr_op_e'(r[1:0]), addr_list[idx], wd, '0);
    end
    read_all();
    end_test();

    test_name = "zero_operand";
    foreach (addr_list[i]) begin
      access(CSR_OP_SET, addr_list[i], '0, '0);
      access(CSR_OP_CLEAR, addr_list[i], '0, '0);
    end
    read_all();
    end_test();

    test_name = "illegal_access";
    access(CSR_OP_READ, csr_num_e'(12'h301), '0, '0);
    access(CSR_OP_WRITE, csr_num_e'(12'h000), 32'hFFFF_FFFF, '0);
    access(CSR_OP_SET, csr_num_e'(12'h7C0), 32'h0000_0001, '0);
    access(CSR_OP_WRITE, CSR_MHARTID, 32'h1234_5678, '0);
    access(CSR_OP_SET, CSR_MHARTID, 32'h0000_0001, '0);
    access(CSR_OP_CLEAR, CSR_MHARTID, 32'h0000_0001, '0);
    read_all();
    end_test();

    test_name = "suppressed";
    foreach (addr_list[i]) begin
      ct         = '0;
      ct.kill_wb = 1'b1;
      access(CSR_OP_WRITE, addr_list[i], 32'hFFFF_FFFF, ct);
      ct         = '0;
      ct.halt_wb = 1'b1;
      access(CSR_OP_SET, addr_list[i], 32'h5555_5555, ct);
    end
    access(CSR_OP_WRITE, csr_num_e'(12'h123), '1, ct);
    // Without valid nothing executes
    rq       = '0;
    rq.op    = CSR_OP_WRITE;
    rq.addr  = CSR_MSCRATCH;
    rq.wdata = 32'hA5A5_0F0F;
    present(rq, '0);
    rq.addr = CSR_MHARTID;
    present(rq, '0);
    read_all();
    end_test();

    test_name = "trap_mret";
    access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008, '0);
    ct                = '0;
    ct.csr_save_cause = 1'b1;
    ct.cause_irq      = 1'b1;
    ct.cause_code     = 5'd11;
    ct.pipe_pc        = 32'h0000_2345;
    // The mscratch write shares the cycle with the save and is lost
    access(CSR_OP_WRITE, CSR_MSCRATCH, 32'hDEAD_BEEF, ct);
    read_all();
    ct                  = '0;
    ct.csr_restore_mret = 1'b1;
    access(CSR_OP_WRITE, CSR_MEPC, 32'h0000_1000, ct);
    read_all();
    // Save and mret together with MIE low, the save wins
    access(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0000, '0);
    ct                  = '0;
    ct.csr_save_cause   = 1'b1;
    ct.csr_restore_mret = 1'b1;
    ct.cause_code       = 5'd2;
    ct.pipe_pc          = 32'h0000_0800;
    access(CSR_OP_READ, CSR_MCAUSE, '0, ct);
    read_all();
    ct                  = '0;
    ct.csr_restore_mret = 1'b1;
    access(CSR_OP_READ, CSR_MSTATUS, '0, ct);
    read_all();
    end_test();

    $display("Tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+tb
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_write_unit.sv
hdl/csr_regs.sv
hdl/csr_top.sv
tb/csr_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the CSR file testbench with Verilator
verilator --binary --timing --top-module csr_tb -f vlog.f -o csr_sim > build.log 2>&1 \
  && ./obj_dir/csr_sim > sim.log 2>&1 \
  || { echo "Build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation reported errors"; exit 1; } \
  || { echo "Simulation clean"; exit 0; }
